// ==== all.f ====
rtl/scsiDmaPkg.sv
rtl/dmaFifo.sv
rtl/scsiFsm.sv
rtl/scsiSm.sv
rtl/scsiDmaTop.sv
dv/scsiDma_assert.sv
dv/scsiDmaTb.sv

// ==== Makefile ====
# Verilator build and run of the SCSI DMA testbench
TOP := scsiDmaTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

// ==== dv/scsiDmaTb.sv ====
////////////////////////////////////////////////////////////
// SCSI DMA testbench
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module scsiDmaTb;
    import scsiDmaPkg::*;

    localparam int CYCLE_LIMIT = 3000;       // Several times the whole sequence

    logic BCLK;
    logic CRESET_;
    logic dreq_i;
    logic dack_o;
    logic scsiCs_o;
    logic re_o;
    logic we_o;
    byteT scsiData_i;
    byteT scsiData_o;
    logic cpuReq_i;
    logic rw_i;
    logic as_i;
    logic ls2cpu_o;
    logic dmaDir_i;
    logic memWrStb_i;
    longT memWrData_i;
    logic memRdStb_i;
    longT memRdData_o;
    logic fifoFull_o;
    logic fifoEmpty_o;

    byteT       chipBytes[$];                // Bytes the chip model still gives
    byteT       gotBytes[$];                 // Bytes the chip model took
    longT       expLongs[$];                 // Longwords expected on the memory side
    byteT       regFile[8];                  // Chip register file
    logic [2:0] hostAddr;                    // Host bus address to the chip
    byteT       hostWrData;
    byteT       hostRdData;
    int         dmaLeft = 0;                 // Byte cycles the chip still wants
    logic       takeByte = 1'b0;
    int         errors = 0;
    int         cycles = 0;

    scsiDmaTop scsiDmaTop_i (.*);

    bind scsiDmaTop scsiDmaAssert scsiDmaAssert_i (
        .BCLK        (BCLK),
        .CRESET_     (CRESET_),
        .dreq_i      (dreq_i),
        .dack_i      (dack_o),
        .re_i        (re_o),
        .we_i        (we_o),
        .scsiCs_i    (scsiCs_o),
        .as_i        (as_i),
        .ls2cpu_i    (ls2cpu_o),
        .dmaDir_i    (dmaDir_i),
        .fifoFull_i  (fifoFull_o),
        .fifoEmpty_i (fifoEmpty_o),
        .fsmState_i  (scsiSm_i.scsiFsm_i.state)
    );

    initial begin
        BCLK = 1'b0;
        forever #50 BCLK = ~BCLK;            // 100 ns period
    end

    always @(posedge BCLK) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

    // Chip model drives request and data on the rising edge
    always @(posedge BCLK) begin
        if (takeByte) begin
            void'(chipBytes.pop_front());    // FIFO sampled the old byte here
            takeByte = 1'b0;
        end
        dreq_i     <= (dmaLeft == 0);        // Low while work is left
        scsiData_i <= (chipBytes.size() > 0) ? chipBytes[0] : '0;
    end

    // Chip model samples the strobes mid-cycle
    always @(negedge BCLK) begin
        if (dack_o) begin
            if (dmaLeft == 0) begin
                errors++;
                $display("DMA byte cycle at %0t ns with no byte requested", $time);
            end else begin
                dmaLeft--;
            end
            if (re_o) takeByte = 1'b1;
            if (we_o) gotBytes.push_back(scsiData_o);
        end
        if (scsiCs_o && we_o) regFile[hostAddr] = hostWrData;
        if (scsiCs_o && re_o) hostRdData = regFile[hostAddr];
    end

    function automatic void checkValue(input longT got, input longT exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endfunction

    task automatic pushLong(input longT data);
        @(posedge BCLK);
        memWrStb_i  <= 1'b1;
        memWrData_i <= data;
        @(posedge BCLK);
        memWrStb_i  <= 1'b0;
    endtask

    task automatic popCheck(input longT exp, input string what);
        @(negedge BCLK);
        checkValue(memRdData_o, exp, what);  // Head valid before the strobe
        @(posedge BCLK);
        memRdStb_i <= 1'b1;
        @(posedge BCLK);
        memRdStb_i <= 1'b0;
    endtask

    task automatic hostCycle(input logic rd, input logic [2:0] addr, input byteT data);
        @(negedge BCLK);
        hostAddr   = addr;
        hostWrData = data;
        @(posedge BCLK);
        rw_i     <= rd;
        cpuReq_i <= 1'b1;
        as_i     <= 1'b1;
        while (!ls2cpu_o) @(negedge BCLK);   // Cycle length varies
        @(posedge BCLK);
        cpuReq_i <= 1'b0;
        as_i     <= 1'b0;
        while (ls2cpu_o) @(negedge BCLK);
    endtask

    initial begin
        longT word;
        byteT data;
        int   assertFails;
        void'($urandom(92));
        CRESET_     = 1'b1;
        dreq_i      = 1'b1;
        scsiData_i  = '0;
        cpuReq_i    = 1'b0;
        rw_i        = 1'b0;
        as_i        = 1'b0;
        dmaDir_i    = 1'b1;
        memWrStb_i  = 1'b0;
        memWrData_i = '0;
        memRdStb_i  = 1'b0;
        #1 CRESET_  = 1'b0;                  // Real falling edge for the async reset
        repeat (10) @(posedge BCLK);
        CRESET_ <= 1'b1;
        repeat (2) @(posedge BCLK);

        // SCSI to FIFO, 16 bytes packed little-endian
        @(negedge BCLK);
        for (int i = 0; i < 16; i++) begin
            data = byteT'($urandom);
            chipBytes.push_back(data);
            word[(i % 4) * BYTE_W +: BYTE_W] = data;
            if (i % 4 == 3) expLongs.push_back(word);
        end
        dmaLeft = 16;
        while (dmaLeft > 0) @(negedge BCLK);
        repeat (3) @(posedge BCLK);          // Last commit lands
        for (int i = 0; i < 4; i++) popCheck(expLongs.pop_front(), "inbound longword");

        // FIFO to SCSI, 3 longwords out as 12 bytes
        @(posedge BCLK);
        dmaDir_i <= 1'b0;
        for (int i = 0; i < 3; i++) begin
            word = $urandom;
            expLongs.push_back(word);
            pushLong(word);
        end
        @(negedge BCLK);
        dmaLeft = 12;
        while (gotBytes.size() < 12) @(negedge BCLK);
        for (int i = 0; i < 3; i++) begin
            word = expLongs.pop_front();
            for (int k = 0; k < 4; k++) begin
                checkValue(gotBytes.pop_front(), word[k * BYTE_W +: BYTE_W], "outbound byte");
            end
        end

        // Full FIFO blocks inbound cycles and drops an extra push
        @(posedge BCLK);
        dmaDir_i <= 1'b1;
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            word = $urandom;
            expLongs.push_back(word);
            pushLong(word);
        end
        pushLong(~expLongs[0]);
        @(negedge BCLK);
        checkValue(fifoFull_o, 1'b1, "fifoFull_o");
        for (int i = 0; i < 4; i++) chipBytes.push_back(byteT'($urandom));
        dmaLeft = 4;
        repeat (30) @(posedge BCLK);
        @(negedge BCLK);
        if (dmaLeft != 4) begin
            errors++;
            $display("DMA byte cycle ran while the FIFO was full");
        end
        dmaLeft = 0;
        chipBytes.delete();
        repeat (4) @(posedge BCLK);          // Request release reaches the FSM
        for (int i = 0; i < FIFO_DEPTH; i++) popCheck(expLongs.pop_front(), "readback");

        // Empty FIFO blocks outbound cycles
        @(posedge BCLK);
        dmaDir_i <= 1'b0;
        @(negedge BCLK);
        checkValue(fifoEmpty_o, 1'b1, "fifoEmpty_o");
        dmaLeft = 4;
        repeat (30) @(posedge BCLK);
        @(negedge BCLK);
        if (dmaLeft != 4 || gotBytes.size() != 0) begin
            errors++;
            $display("DMA byte cycle ran while the FIFO was empty");
        end
        dmaLeft = 0;
        repeat (4) @(posedge BCLK);

        // Host register write, other write, then read back
        data = byteT'($urandom);
        hostCycle(1'b0, 3'd5, data);
        hostCycle(1'b0, 3'd2, ~data);
        hostCycle(1'b1, 3'd5, '0);
        checkValue(hostRdData, data, "register read");

        repeat (5) @(posedge BCLK);
        assertFails = scsiDmaTop_i.scsiDmaAssert_i.failCount;
        $display("summary: %0d data errors, %0d assertion failures", errors, assertFails);
        if (errors == 0 && assertFails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/scsiDma_assert.sv ====
////////////////////////////////////////////////////////////
// SCSI DMA protocol assertions
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module scsiDmaAssert (
    input logic                  BCLK,          // System clock
    input logic                  CRESET_,       // Async reset, active low
    input logic                  dreq_i,        // Chip DMA request, active low
    input logic                  dack_i,        // DMA acknowledge
    input logic                  re_i,          // Chip read strobe
    input logic                  we_i,          // Chip write strobe
    input logic                  scsiCs_i,      // Chip select
    input logic                  as_i,          // Host address strobe
    input logic                  ls2cpu_i,      // Host cycle termination
    input logic                  dmaDir_i,      // 1 = SCSI to FIFO
    input logic                  fifoFull_i,    // FIFO full
    input logic                  fifoEmpty_i,   // FIFO empty
    input scsiDmaPkg::scsiStateT fsmState_i     // Sequencer state
);
    import scsiDmaPkg::*;

    int failCount = 0;                          // Failed checks so far

    // Outputs quiet and FIFO empty while reset is held
    resetIdle: assert property (@(posedge BCLK)
        !CRESET_ |-> !dack_i && !re_i && !we_i && !scsiCs_i && !ls2cpu_i && fifoEmpty_i)
        else begin
            $error("outputs not idle during reset");
            failCount = failCount + 1;
        end

    dackOneCycle: assert property (@(posedge BCLK) disable iff (!CRESET_)
        dack_i |=> !dack_i)                     // Byte strobe is a single pulse
        else begin
            $error("dack_o held longer than one cycle");
            failCount = failCount + 1;
        end

    dackNotCs: assert property (@(posedge BCLK) disable iff (!CRESET_)
        !(dack_i && scsiCs_i))                  // DMA and register cycles never overlap
        else begin
            $error("dack_o together with scsiCs_o");
            failCount = failCount + 1;
        end

    strobesApart: assert property (@(posedge BCLK) disable iff (!CRESET_)
        !(re_i && we_i))
        else begin
            $error("re_o and we_o high together");
            failCount = failCount + 1;
        end

    // Inbound needs room, outbound needs data
    dackFlags: assert property (@(posedge BCLK) disable iff (!CRESET_)
        dack_i |-> (dmaDir_i ? !fifoFull_i : !fifoEmpty_i))
        else begin
            $error("byte cycle ran against a full or empty FIFO");
            failCount = failCount + 1;
        end

    lsHold: assert property (@(posedge BCLK) disable iff (!CRESET_)
        ls2cpu_i && as_i |=> ls2cpu_i)          // Termination held while strobe stays
        else begin
            $error("ls2cpu_o dropped before as_i released");
            failCount = failCount + 1;
        end

    lsRelease: assert property (@(posedge BCLK) disable iff (!CRESET_)
        ls2cpu_i && !as_i |=> !ls2cpu_i)
        else begin
            $error("ls2cpu_o still high after as_i released");
            failCount = failCount + 1;
        end

    // Byte cycle entered only when the pin request was low, one sync stage back
    dmaOnRequest: assert property (@(posedge BCLK) disable iff (!CRESET_)
        fsmState_i inside {DMA_RD, DMA_WR} |-> !$past(dreq_i, 2))
        else begin
            $error("byte cycle started without a DMA request");
            failCount = failCount + 1;
        end

endmodule

`default_nettype wire

// ==== rtl/scsiDmaTop.sv ====
////////////////////////////////////////////////////////////
// SCSI DMA subsystem top
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module scsiDmaTop (
    input  logic               BCLK,          // System clock
    input  logic               CRESET_,       // Async reset, active low
    input  logic               dreq_i,        // Chip DMA request, active low
    output logic               dack_o,        // DMA acknowledge
    output logic               scsiCs_o,      // Chip select
    output logic               re_o,          // Chip read strobe
    output logic               we_o,          // Chip write strobe
    input  scsiDmaPkg::byteT   scsiData_i,    // Byte from chip
    output scsiDmaPkg::byteT   scsiData_o,    // Byte to chip
    input  logic               cpuReq_i,      // Host register request
    input  logic               rw_i,          // Host direction, 1 = read
    input  logic               as_i,          // Host address strobe
    output logic               ls2cpu_o,      // Host cycle termination
    input  logic               dmaDir_i,      // 1 = SCSI to FIFO
    input  logic               memWrStb_i,    // Memory side push
    input  scsiDmaPkg::longT   memWrData_i,   // Memory side write data
    input  logic               memRdStb_i,    // Memory side pop
    output scsiDmaPkg::longT   memRdData_o,   // Head longword
    output logic               fifoFull_o,    // FIFO full
    output logic               fifoEmpty_o    // FIFO empty
);

    logic incBo;
    logic incNi;
    logic incNo;
    logic s2f;
    logic f2s;
    logic boEq3;

    scsiSm scsiSm_i (
        .BCLK        (BCLK),
        .CRESET_     (CRESET_),
        .dreq_i      (dreq_i),
        .cpuReq_i    (cpuReq_i),
        .rw_i        (rw_i),
        .as_i        (as_i),
        .dmaDir_i    (dmaDir_i),
        .boEq3_i     (boEq3),
        .fifoFull_i  (fifoFull_o),
        .fifoEmpty_i (fifoEmpty_o),
        .dack_o      (dack_o),
        .re_o        (re_o),
        .we_o        (we_o),
        .scsiCs_o    (scsiCs_o),
        .ls2cpu_o    (ls2cpu_o),
        .incBo_o     (incBo),
        .incNi_o     (incNi),
        .incNo_o     (incNo),
        .s2f_o       (s2f),
        .f2s_o       (f2s)
    );

    dmaFifo dmaFifo_i (
        .BCLK        (BCLK),
        .CRESET_     (CRESET_),
        .incBo_i     (incBo),
        .incNi_i     (incNi),
        .incNo_i     (incNo),
        .s2f_i       (s2f),
        .f2s_i       (f2s),
        .scsiData_i  (scsiData_i),
        .memWrStb_i  (memWrStb_i),
        .memWrData_i (memWrData_i),
        .memRdStb_i  (memRdStb_i),
        .scsiData_o  (scsiData_o),
        .memRdData_o (memRdData_o),
        .boEq3_o     (boEq3),
        .fifoFull_o  (fifoFull_o),
        .fifoEmpty_o (fifoEmpty_o)
    );

endmodule

`default_nettype wire

// ==== rtl/scsiSm.sv ====
////////////////////////////////////////////////////////////
// SCSI state machine wrapper
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module scsiSm (
    input  logic BCLK,              // System clock
    input  logic CRESET_,           // Async reset, active low
    input  logic dreq_i,            // Chip DMA request, active low
    input  logic cpuReq_i,          // Host register access request
    input  logic rw_i,              // Host direction, 1 = read
    input  logic as_i,              // Host address strobe, low = released
    input  logic dmaDir_i,          // 1 = SCSI to FIFO
    input  logic boEq3_i,           // Byte pointer at byte 3
    input  logic fifoFull_i,        // FIFO full flag
    input  logic fifoEmpty_i,       // FIFO empty flag
    output logic dack_o,            // DMA acknowledge to chip
    output logic re_o,              // Chip read strobe
    output logic we_o,              // Chip write strobe
    output logic scsiCs_o,          // Chip select
    output logic ls2cpu_o,          // Host cycle termination
    output logic incBo_o,           // Advance byte pointer
    output logic incNi_o,           // Commit packed longword
    output logic incNo_o,           // Free head longword
    output logic s2f_o,             // SCSI to FIFO path enable
    output logic f2s_o              // FIFO to SCSI path enable
);

    logic cDreq;                    // Synchronized DMA request, active low
    logic cCpuReq;                  // Synchronized host request
    logic cDsack;                   // Synchronized termination feedback
    logic fsmCpuReq;                // Host request as seen by the FSM

    logic cpu2s;
    logic dack;
    logic f2s;
    logic s2f;
    logic s2cpu;
    logic incBo;
    logic incNi;
    logic incNo;
    logic re;
    logic we;
    logic scsiCs;
    logic setDsack;

    // No new host cycle while the previous one is still terminating
    assign fsmCpuReq = cCpuReq & ~cDsack;

    scsiFsm scsiFsm_i (
        .BCLK        (BCLK),
        .CRESET_     (CRESET_),
        .boEq3_i     (boEq3_i),
        .cpuReq_i    (fsmCpuReq),
        .dreq_i      (cDreq),
        .dmaDir_i    (dmaDir_i),
        .fifoFull_i  (fifoFull_i),
        .fifoEmpty_i (fifoEmpty_i),
        .rw_i        (rw_i),
        .cpu2s_o     (cpu2s),
        .dack_o      (dack),
        .f2s_o       (f2s),
        .s2f_o       (s2f),
        .s2cpu_o     (s2cpu),
        .incBo_o     (incBo),
        .incNi_o     (incNi),
        .incNo_o     (incNo),
        .re_o        (re),
        .we_o        (we),
        .scsiCs_o    (scsiCs),
        .setDsack_o  (setDsack)
    );

    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            cDreq   <= 1'b1;                              // Request idle is high
            cCpuReq <= 1'b0;
            cDsack  <= 1'b0;
        end else begin
            cDreq   <= dreq_i;
            cCpuReq <= cpuReq_i;
            cDsack  <= ls2cpu_o;                          // Latch fed back one cycle late
        end
    end

    // Registered control outputs
    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            dack_o   <= 1'b0;
            re_o     <= 1'b0;
            we_o     <= 1'b0;
            scsiCs_o <= 1'b0;
            incBo_o  <= 1'b0;
            incNi_o  <= 1'b0;
            incNo_o  <= 1'b0;
            s2f_o    <= 1'b0;
            f2s_o    <= 1'b0;
        end else begin
            dack_o   <= dack;
            re_o     <= re | s2cpu;                       // DMA byte or register read
            we_o     <= we | cpu2s;                       // DMA byte or register write
            scsiCs_o <= scsiCs;
            incBo_o  <= incBo;
            incNi_o  <= incNi;
            incNo_o  <= incNo;
            s2f_o    <= s2f;
            f2s_o    <= f2s;
        end
    end

    // Termination latch, set by the FSM and held until the strobe drops
    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            ls2cpu_o <= 1'b0;
        end else if (setDsack) begin
            ls2cpu_o <= 1'b1;
        end else if (!as_i) begin
            ls2cpu_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/scsiFsm.sv ====
////////////////////////////////////////////////////////////
// SCSI transfer state machine
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module scsiFsm (
    input  logic BCLK,              // System clock
    input  logic CRESET_,           // Async reset, active low
    input  logic boEq3_i,           // Byte pointer at byte 3
    input  logic cpuReq_i,          // Synchronized host request, blocked while terminating
    input  logic dreq_i,            // Synchronized chip DMA request, active low
    input  logic dmaDir_i,          // 1 = SCSI to FIFO
    input  logic fifoFull_i,        // FIFO has no free longword
    input  logic fifoEmpty_i,       // FIFO has no longword
    input  logic rw_i,              // Host direction, 1 = read
    output logic cpu2s_o,           // Host to chip register write
    output logic dack_o,            // DMA acknowledge to chip
    output logic f2s_o,             // FIFO to SCSI path enable
    output logic s2f_o,             // SCSI to FIFO path enable
    output logic s2cpu_o,           // Chip to host register read
    output logic incBo_o,           // Advance byte pointer
    output logic incNi_o,           // Commit packed longword
    output logic incNo_o,           // Free head longword
    output logic re_o,              // Chip read strobe for a DMA byte
    output logic we_o,              // Chip write strobe for a DMA byte
    output logic scsiCs_o,          // Chip select for register access
    output logic setDsack_o         // Set host termination latch
);
    import scsiDmaPkg::*;

    scsiStateT state;               // Current state
    scsiStateT nextState;
    logic      endHold;             // Second cycle of an END state
    logic      nextHold;
    logic      dmaGo;               // A byte cycle may start

    // Chip requests and FIFO has room or data for the chosen direction
    assign dmaGo = ~dreq_i & (dmaDir_i ? ~fifoFull_i : ~fifoEmpty_i);

    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            state   <= IDLE;
            endHold <= 1'b0;
        end else begin
            state   <= nextState;
            endHold <= nextHold;
        end
    end

    always_comb begin
        nextState = state;
        nextHold  = 1'b0;
        case (state)
            IDLE: begin
                if (dmaGo) begin                          // DMA wins when both ask
                    nextState = dmaDir_i ? DMA_RD : DMA_WR;
                end else if (cpuReq_i) begin
                    nextState = rw_i ? CPU_RD : CPU_WR;
                end
            end
            DMA_RD, DMA_WR: nextState = DMA_END;
            CPU_RD, CPU_WR: nextState = CPU_END;
            DMA_END, CPU_END: begin
                // Two cycles here let the request and flags settle
                nextHold = ~endHold;
                if (endHold) begin
                    nextState = IDLE;
                end
            end
            default: nextState = IDLE;
        endcase
    end

    // Outputs decoded from state, registered in the wrapper
    always_comb begin
        dack_o     = 1'b0;
        re_o       = 1'b0;
        we_o       = 1'b0;
        s2f_o      = 1'b0;
        f2s_o      = 1'b0;
        incBo_o    = 1'b0;
        incNi_o    = 1'b0;
        incNo_o    = 1'b0;
        scsiCs_o   = 1'b0;
        s2cpu_o    = 1'b0;
        cpu2s_o    = 1'b0;
        setDsack_o = 1'b0;
        case (state)
            DMA_RD: begin
                dack_o  = 1'b1;
                re_o    = 1'b1;
                s2f_o   = 1'b1;
                incBo_o = 1'b1;
                incNi_o = boEq3_i;                        // Last byte of the longword
            end
            DMA_WR: begin
                dack_o  = 1'b1;
                we_o    = 1'b1;
                f2s_o   = 1'b1;
                incBo_o = 1'b1;
                incNo_o = boEq3_i;                        // Head longword fully sent
            end
            CPU_RD: begin
                scsiCs_o = 1'b1;
                s2cpu_o  = 1'b1;
            end
            CPU_WR: begin
                scsiCs_o = 1'b1;
                cpu2s_o  = 1'b1;
            end
            CPU_END: setDsack_o = ~endHold;               // One pulse per host cycle
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/dmaFifo.sv ====
////////////////////////////////////////////////////////////
// Longword FIFO with byte packing
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module dmaFifo (
    input  logic               BCLK,          // System clock
    input  logic               CRESET_,       // Async reset, active low
    input  logic               incBo_i,       // Advance byte pointer
    input  logic               incNi_i,       // Commit packed longword
    input  logic               incNo_i,       // Free head longword
    input  logic               s2f_i,         // SCSI to FIFO byte cycle
    input  logic               f2s_i,         // FIFO to SCSI byte cycle
    input  scsiDmaPkg::byteT   scsiData_i,    // Byte from chip
    input  logic               memWrStb_i,    // Push one longword
    input  scsiDmaPkg::longT   memWrData_i,   // Longword to push
    input  logic               memRdStb_i,    // Pop one longword
    output scsiDmaPkg::byteT   scsiData_o,    // Byte to chip
    output scsiDmaPkg::longT   memRdData_o,   // Head longword
    output logic               boEq3_o,       // Byte pointer at byte 3
    output logic               fifoFull_o,    // No free longword
    output logic               fifoEmpty_o    // No longword held
);
    import scsiDmaPkg::*;

    longT               mem [FIFO_DEPTH];    // Longword storage
    longT               stage;               // Inbound bytes being packed
    longT               packWord;            // Stage with the current byte merged
    logic [FIFO_AW-1:0] nextIn;              // Write pointer
    logic [FIFO_AW-1:0] nextOut;             // Read pointer
    logic [FIFO_AW:0]   count;               // Longwords held
    logic [1:0]         bytePtr;             // Byte within the longword
    logic               capture;             // Inbound byte taken this cycle
    logic               commit;              // Packed longword pushed
    logic               push;
    logic               pop;

    assign fifoFull_o  = (count == (FIFO_AW+1)'(FIFO_DEPTH));
    assign fifoEmpty_o = (count == '0);
    assign boEq3_o     = (bytePtr == 2'd3);
    assign memRdData_o = mem[nextOut];       // Valid ahead of the pop strobe

    // Outbound byte picked from the head longword, little-endian
    assign scsiData_o = f2s_i ? memRdData_o[bytePtr*BYTE_W +: BYTE_W] : '0;

    assign capture = incBo_i & s2f_i;
    assign commit  = incNi_i & s2f_i;
    assign push    = (commit | memWrStb_i) & ~fifoFull_o;             // Dropped when full
    assign pop     = ((incNo_i & f2s_i) | memRdStb_i) & ~fifoEmpty_o;  // Dropped when empty

    always_comb begin
        packWord = stage;
        packWord[bytePtr*BYTE_W +: BYTE_W] = scsiData_i;
    end

    // Longword storage and inbound staging
    always_ff @(posedge BCLK) begin
        if (capture) begin
            stage <= packWord;
        end
        if (push) begin
            mem[nextIn] <= commit ? packWord : memWrData_i;   // Byte path wins
        end
    end

    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            nextIn  <= '0;
            nextOut <= '0;
            count   <= '0;
            bytePtr <= '0;
        end else begin
            if (incBo_i) begin
                bytePtr <= bytePtr + 2'd1;            // Wraps after byte 3
            end
            if (push) begin
                nextIn <= nextIn + 1'b1;
            end
            if (pop) begin
                nextOut <= nextOut + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;              // Both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/scsiDmaPkg.sv ====
////////////////////////////////////////////////////////////
// SCSI DMA shared definitions
////////////////////////////////////////////////////////////
`default_nettype none

package scsiDmaPkg;

    localparam int BYTE_W     = 8;           // SCSI data bus width
    localparam int LONG_W     = 32;          // FIFO word width
    localparam int FIFO_DEPTH = 8;           // Longwords held in the FIFO
    localparam int FIFO_AW    = 3;           // FIFO pointer width

    typedef logic [BYTE_W-1:0] byteT;        // One byte on the SCSI bus
    typedef logic [LONG_W-1:0] longT;        // One FIFO longword, byte 0 in bits 7..0

    // Transfer sequencer states
    typedef enum logic [2:0] {
        IDLE    = 3'd0,                      // Waiting for a DMA or host request
        DMA_RD  = 3'd1,                      // Byte from chip into FIFO
        DMA_WR  = 3'd2,                      // Byte from FIFO to chip
        DMA_END = 3'd3,                      // Recovery after a byte cycle
        CPU_RD  = 3'd4,                      // Host reads a chip register
        CPU_WR  = 3'd5,                      // Host writes a chip register
        CPU_END = 3'd6                       // Host cycle termination
    } scsiStateT;

endpackage

`default_nettype wire
